//--- verif/itim_stim.txt
// Columns: operation (1 fetch, 2 fence, 0 end), byte address, expected Wishbone reads
// All values are hexadecimal
2 00000000 0
1 00000100 2
1 00000100 0
1 00020040 2
1 00020040 2
1 0000fffc 2
1 0000fffc 2
1 00000500 2
1 00000500 2
1 00000100 0
1 0000020c 2
1 0000020c 0
1 00000210 2
1 00000210 0
1 0000020c 0
1 00000208 2
1 00000208 0
2 00000000 0
1 00000100 2
1 00000100 0
0 00000000 0

//--- itim_top.f
common/mem_bus_pkg.sv
common/itim_cfg_pkg.sv
common/itim_ram_if.sv
common/fetch_req_if.sv
common/mem_req_if.sv
itim/itim_ram.sv
itim/itim_ctrl.sv
hdl/fetch_front.sv
hdl/wb_fetch_master.sv
hdl/itim_top.sv
verif/itim_tb.sv

//--- Makefile
.PHONY: all build lint clean

all: build
	./obj_dir/itim_sim

build:
	verilator --binary --timing -j 0 --top-module itim_tb -o itim_sim -f itim_top.f

lint:
	verilator --lint-only --timing --top-module itim_top -f itim_top.f

clean:
	rm -rf obj_dir

//--- verif/itim_tb.sv
`timescale 1ns/100ps

module itim_tb;
  import mem_bus_pkg::*;

  localparam logic [31:0] op_end = 32'h0;
  localparam logic [31:0] op_fetch = 32'h1;
  localparam logic [31:0] op_fence = 32'h2;
  localparam int max_ops = 32;
  localparam int ready_timeout = 400;
  localparam word_t model_pattern = 32'h5a5a_a5a5;

  logic clock = 1'b0;
  logic reset;
  logic fetch_valid;
  logic fetch_fence;
  addr_t fetch_addr;
  dword_t fetch_rdata;
  logic fetch_ready;
  word_t wb_rdata = '0;
  logic wb_ack = 1'b0;
  logic wb_cyc;
  logic wb_stb;
  addr_t wb_adr;

  // Three words per operation: code, address, expected bus reads
  logic [31:0] stim [3*max_ops];
  int acked_reads = 0;
  logic waiting = 1'b0;
  int unsigned wait_left = 0;
  bit seeded = 1'b0;

  always #2 clock = ~clock;

  itim_top DUT (
    .clock(clock),
    .reset(reset),
    .fetch_valid(fetch_valid),
    .fetch_fence(fetch_fence),
    .fetch_addr(fetch_addr),
    .fetch_rdata(fetch_rdata),
    .fetch_ready(fetch_ready),
    .wb_rdata(wb_rdata),
    .wb_ack(wb_ack),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_adr(wb_adr)
  );

  // Backing memory content is a fixed function of the word address
  function automatic word_t model_word(input addr_t addr);
    return addr ^ model_pattern;
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("STATUS: FAIL");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, expected);
      stop_with_failure("Value mismatch");
    end
  endtask

  // Wishbone slave that acks each strobe after 0 to 3 wait states
  always @(posedge clock) begin : memory_model
    int unsigned delay;
    if (!seeded) begin
      void'($urandom(32'h657c6824));
      seeded = 1'b1;
    end
    if (!reset) begin
      wb_ack <= 1'b0;
      waiting <= 1'b0;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;
    end else if (wb_cyc && wb_stb) begin
      delay = waiting ? wait_left : $urandom % 4;
      if (delay == 0) begin
        wb_ack <= 1'b1;
        wb_rdata <= model_word(wb_adr);
        waiting <= 1'b0;
        acked_reads <= acked_reads + 1;
      end else begin
        waiting <= 1'b1;
        wait_left <= delay - 1;
      end
    end
  end

  initial begin
    int op_index;
    int start_reads;
    int wait_cycles;
    logic ready_seen;
    logic [31:0] op;
    addr_t addr;
    logic [31:0] expected_reads;

    reset = 1'b0;
    fetch_valid = 1'b0;
    fetch_fence = 1'b0;
    fetch_addr = '0;
    $readmemh("verif/itim_stim.txt", stim);

    repeat (4) @(posedge clock);
    reset <= 1'b1;

    for (op_index = 0; op_index < max_ops; op_index++) begin
      op = stim[3*op_index];
      addr = stim[3*op_index+1];
      expected_reads = stim[3*op_index+2];
      if (op === op_end) break;
      if (op !== op_fetch && op !== op_fence) begin
        stop_with_failure("Unknown operation code in the stimulus file");
      end

      @(posedge clock);
      start_reads = acked_reads;
      fetch_valid <= 1'b1;
      fetch_fence <= op === op_fence;
      fetch_addr <= addr;
      @(posedge clock);
      fetch_valid <= 1'b0;
      fetch_fence <= 1'b0;

      // Outputs are sampled on the falling edge, away from the driving edge
      wait_cycles = 0;
      ready_seen = 1'b0;
      while (!ready_seen) begin
        @(negedge clock);
        wait_cycles++;
        if (fetch_ready) begin
          ready_seen = 1'b1;
        end else if (wait_cycles >= ready_timeout) begin
          stop_with_failure("Timeout while waiting for fetch_ready");
        end
      end

      if (op === op_fetch) begin
        check_value("fetch_rdata", fetch_rdata,
                    {model_word(addr + 32'd4), model_word(addr)});
        // A hit answers in the cycle right after the request
        if (expected_reads == 0) begin
          check_value("hit latency in cycles", 64'(wait_cycles), 64'd1);
        end
      end
      check_value("Wishbone reads", 64'(acked_reads - start_reads), 64'(expected_reads));
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- hdl/itim_top.sv
`timescale 1ns/100ps

module itim_top #(
  parameter int itim_depth = itim_cfg_pkg::default_depth,
  parameter int itim_width = itim_cfg_pkg::default_width,
  parameter mem_bus_pkg::addr_t itim_base_addr = itim_cfg_pkg::default_base_addr,
  parameter mem_bus_pkg::addr_t itim_top_addr = itim_cfg_pkg::default_top_addr
) (
  input logic clock,
  input logic reset,
  input logic fetch_valid,
  input logic fetch_fence,
  input mem_bus_pkg::addr_t fetch_addr,
  output mem_bus_pkg::dword_t fetch_rdata,
  output logic fetch_ready,
  input mem_bus_pkg::word_t wb_rdata,
  input logic wb_ack,
  output logic wb_cyc,
  output logic wb_stb,
  output mem_bus_pkg::addr_t wb_adr
);
  import mem_bus_pkg::*;

  localparam int word_bits = $clog2(itim_width);
  localparam int index_bits = $clog2(itim_depth);
  localparam int tag_bits = $bits(addr_t) - 2 - word_bits - index_bits;
  localparam int entry_bits = 1 + tag_bits + $bits(word_t);

  fetch_req_if #(.word_bits(word_bits), .index_bits(index_bits), .tag_bits(tag_bits)) req ();
  itim_ram_if #(.index_bits(index_bits), .entry_bits(entry_bits)) ram_bus [itim_width] ();
  mem_req_if mem ();

  fetch_front #(.itim_depth(itim_depth), .itim_width(itim_width)) u_front (
    .clock(clock),
    .reset(reset),
    .fetch_valid(fetch_valid),
    .fetch_fence(fetch_fence),
    .fetch_addr(fetch_addr),
    .req(req)
  );

  itim_ctrl #(
    .itim_depth(itim_depth),
    .itim_width(itim_width),
    .itim_base_addr(itim_base_addr),
    .itim_top_addr(itim_top_addr)
  ) u_ctrl (
    .clock(clock),
    .reset(reset),
    .req(req),
    .ram(ram_bus),
    .mem(mem),
    .fetch_rdata(fetch_rdata),
    .fetch_ready(fetch_ready)
  );

  for (genvar b = 0; b < itim_width; b++) begin : g_bank
    itim_ram #(.itim_depth(itim_depth), .itim_width(itim_width)) u_ram (
      .clock(clock),
      .ram(ram_bus[b])
    );
  end

  wb_fetch_master u_master (
    .clock(clock),
    .reset(reset),
    .mem(mem),
    .wb_rdata(wb_rdata),
    .wb_ack(wb_ack),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_adr(wb_adr)
  );

endmodule

//--- hdl/wb_fetch_master.sv
`timescale 1ns/100ps

module wb_fetch_master (
  input logic clock,
  input logic reset,
  mem_req_if.responder mem,
  input mem_bus_pkg::word_t wb_rdata,
  input logic wb_ack,
  output logic wb_cyc,
  output logic wb_stb,
  output mem_bus_pkg::addr_t wb_adr
);
  import mem_bus_pkg::*;

  typedef enum logic [1:0] {
    idle,
    busy,
    done
  } bus_state_t;

  bus_state_t state;
  word_t read_data;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= idle;
    end else begin
      case (state)
        idle: if (mem.valid) state <= busy;
        busy: if (wb_ack) state <= done;
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == idle && mem.valid) begin
      wb_adr <= mem.addr;
    end
    if (state == busy && wb_ack) begin
      read_data <= wb_rdata;
    end
  end

  // The done cycle keeps cyc low between two reads
  assign wb_cyc = state == busy;
  assign wb_stb = state == busy;
  assign mem.ready = state == done;
  assign mem.rdata = read_data;

endmodule

//--- hdl/fetch_front.sv
`timescale 1ns/100ps

module fetch_front #(
  parameter int itim_depth = itim_cfg_pkg::default_depth,
  parameter int itim_width = itim_cfg_pkg::default_width
) (
  input logic clock,
  input logic reset,
  input logic fetch_valid,
  input logic fetch_fence,
  input mem_bus_pkg::addr_t fetch_addr,
  fetch_req_if.request req
);
  import mem_bus_pkg::*;

  localparam int word_bits = $clog2(itim_width);
  localparam int index_bits = $clog2(itim_depth);
  localparam int tag_low = word_bits + index_bits + 2;

  addr_t next_addr1;

  assign next_addr1 = fetch_addr + 32'd4;

  // Fields of the incoming request, used for the bank reads in this cycle
  assign req.next_word0 = fetch_addr[word_bits+1:2];
  assign req.next_word1 = next_addr1[word_bits+1:2];
  assign req.next_index0 = fetch_addr[tag_low-1:word_bits+2];
  assign req.next_index1 = next_addr1[tag_low-1:word_bits+2];

  always_ff @(posedge clock) begin
    if (!reset) begin
      req.enable <= 1'b0;
      req.fence <= 1'b0;
    end else begin
      req.enable <= fetch_valid;
      req.fence <= fetch_valid && fetch_fence;
    end
  end

  // Held until the next request so the controller can use them during a refill
  always_ff @(posedge clock) begin
    if (fetch_valid) begin
      req.addr0 <= fetch_addr;
      req.addr1 <= next_addr1;
      req.tag0 <= fetch_addr[$bits(addr_t)-1:tag_low];
      req.tag1 <= next_addr1[$bits(addr_t)-1:tag_low];
      req.index0 <= req.next_index0;
      req.index1 <= req.next_index1;
      req.word0 <= req.next_word0;
      req.word1 <= req.next_word1;
    end
  end

endmodule

//--- itim/itim_ctrl.sv
`timescale 1ns/100ps

module itim_ctrl #(
  parameter int itim_depth = itim_cfg_pkg::default_depth,
  parameter int itim_width = itim_cfg_pkg::default_width,
  parameter mem_bus_pkg::addr_t itim_base_addr = itim_cfg_pkg::default_base_addr,
  parameter mem_bus_pkg::addr_t itim_top_addr = itim_cfg_pkg::default_top_addr
) (
  input logic clock,
  input logic reset,
  fetch_req_if.consumer req,
  itim_ram_if.ctrl ram [itim_width],
  mem_req_if.requester mem,
  output mem_bus_pkg::dword_t fetch_rdata,
  output logic fetch_ready
);
  import itim_cfg_pkg::*;
  import mem_bus_pkg::*;

  localparam int word_bits = $clog2(itim_width);
  localparam int index_bits = $clog2(itim_depth);
  localparam int tag_bits = $bits(addr_t) - 2 - word_bits - index_bits;
  localparam int data_bits = $bits(word_t);
  localparam int entry_bits = 1 + tag_bits + data_bits;

  typedef logic [tag_bits-1:0] tag_t;
  typedef logic [index_bits-1:0] index_t;
  typedef logic [word_bits-1:0] word_sel_t;
  typedef logic [entry_bits-1:0] entry_t;

  fetch_state_t state;
  logic second;
  word_t first_word;
  index_t clear_index;

  entry_t bank_rdata [itim_width];
  entry_t entry0;
  entry_t entry1;
  logic lock0;
  logic lock1;
  tag_t tag0;
  tag_t tag1;
  word_t data0;
  word_t data1;
  logic outside;
  logic missing;
  logic mismatch;
  logic last_clear;

  logic fill_wen;
  word_sel_t fill_word;
  index_t fill_index;
  entry_t fill_entry;

  // Each entry is lock, tag, data from the top bit down
  assign entry0 = bank_rdata[req.word0];
  assign entry1 = bank_rdata[req.word1];
  assign lock0 = entry0[entry_bits-1];
  assign lock1 = entry1[entry_bits-1];
  assign tag0 = entry0[entry_bits-2 -: tag_bits];
  assign tag1 = entry1[entry_bits-2 -: tag_bits];
  assign data0 = entry0[data_bits-1:0];
  assign data1 = entry1[data_bits-1:0];

  assign outside = req.addr0 < itim_base_addr || req.addr0 >= itim_top_addr ||
                   req.addr1 < itim_base_addr || req.addr1 >= itim_top_addr;
  assign missing = !lock0 || !lock1;
  assign mismatch = tag0 != req.tag0 || tag1 != req.tag1;
  assign last_clear = clear_index == index_t'(itim_depth - 1);

  // Only a refill writes returned words back, bypass leaves the banks alone
  assign fill_wen = state == refill && mem.ready;
  assign fill_word = second ? req.word1 : req.word0;
  assign fill_index = second ? req.index1 : req.index0;
  assign fill_entry = {1'b1, second ? req.tag1 : req.tag0, mem.rdata};

  for (genvar b = 0; b < itim_width; b++) begin : g_bank
    assign bank_rdata[b] = ram[b].rdata;
    // The two words of a fetch always sit in different banks
    assign ram[b].raddr = (word_sel_t'(b) == req.next_word1) ? req.next_index1
                                                               : req.next_index0;
    assign ram[b].wen = state == fence_clear || (fill_wen && fill_word == word_sel_t'(b));
    assign ram[b].waddr = (state == fence_clear) ? clear_index : fill_index;
    assign ram[b].wdata = (state == fence_clear) ? '0 : fill_entry;
  end

  assign mem.valid = state == refill || state == bypass;
  assign mem.addr = second ? req.addr1 : req.addr0;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= idle_hit;
      second <= 1'b0;
      clear_index <= '0;
    end else begin
      case (state)
        idle_hit: begin
          if (req.enable) begin
            second <= 1'b0;
            clear_index <= '0;
            if (req.fence) begin
              state <= fence_clear;
            end else if (outside) begin
              state <= bypass;
            end else if (missing) begin
              state <= refill;
            end else if (mismatch) begin
              // Valid lines are never evicted
              state <= bypass;
            end
          end
        end
        refill, bypass: begin
          if (mem.ready) begin
            second <= !second;
            if (second) begin
              state <= idle_hit;
            end
          end
        end
        fence_clear: begin
          clear_index <= clear_index + 1'b1;
          if (last_clear) begin
            state <= idle_hit;
          end
        end
        default: state <= idle_hit;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (mem.ready && !second) begin
      first_word <= mem.rdata;
    end
  end

  always_comb begin
    fetch_ready = 1'b0;
    fetch_rdata = {mem.rdata, first_word};
    case (state)
      idle_hit: begin
        fetch_rdata = {data1, data0};
        fetch_ready = req.enable && !req.fence && !outside && !missing && !mismatch;
      end
      refill, bypass: fetch_ready = mem.ready && second;
      fence_clear: fetch_ready = last_clear;
      default: fetch_ready = 1'b0;
    endcase
  end

endmodule

//--- itim/itim_ram.sv
`timescale 1ns/100ps

module itim_ram #(
  parameter int itim_depth = itim_cfg_pkg::default_depth,
  parameter int itim_width = itim_cfg_pkg::default_width
) (
  input logic clock,
  itim_ram_if.bank ram
);
  import mem_bus_pkg::*;

  localparam int word_bits = $clog2(itim_width);
  localparam int index_bits = $clog2(itim_depth);
  localparam int tag_bits = $bits(addr_t) - 2 - word_bits - index_bits;
  localparam int entry_bits = 1 + tag_bits + $bits(word_t);

  typedef logic [index_bits-1:0] index_t;
  typedef logic [entry_bits-1:0] entry_t;

  entry_t mem_array [itim_depth];
  index_t raddr_q;

  always_ff @(posedge clock) begin
    raddr_q <= ram.raddr;
    if (ram.wen) begin
      mem_array[ram.waddr] <= ram.wdata;
    end
  end

  // A write in the cycle before is already visible here
  assign ram.rdata = mem_array[raddr_q];

endmodule

//--- common/mem_req_if.sv
`timescale 1ns/100ps

interface mem_req_if;
  import mem_bus_pkg::*;

  // valid is held with a stable addr until ready pulses
  logic valid;
  addr_t addr;
  logic ready;
  word_t rdata;

  modport requester (
    output valid, addr,
    input ready, rdata
  );

  modport responder (
    input valid, addr,
    output ready, rdata
  );

endinterface

//--- common/fetch_req_if.sv
`timescale 1ns/100ps

interface fetch_req_if #(
  parameter int word_bits = $clog2(itim_cfg_pkg::default_width),
  parameter int index_bits = $clog2(itim_cfg_pkg::default_depth),
  parameter int tag_bits = 30 - word_bits - index_bits
);
  import mem_bus_pkg::*;

  logic enable;
  logic fence;
  addr_t addr0;
  addr_t addr1;
  logic [tag_bits-1:0] tag0;
  logic [tag_bits-1:0] tag1;
  logic [index_bits-1:0] index0;
  logic [index_bits-1:0] index1;
  logic [word_bits-1:0] word0;
  logic [word_bits-1:0] word1;
  // Unregistered fields so the bank reads start with the request
  logic [index_bits-1:0] next_index0;
  logic [index_bits-1:0] next_index1;
  logic [word_bits-1:0] next_word0;
  logic [word_bits-1:0] next_word1;

  modport request (
    output enable, fence, addr0, addr1, tag0, tag1, index0, index1, word0, word1,
    output next_index0, next_index1, next_word0, next_word1
  );

  modport consumer (
    input enable, fence, addr0, addr1, tag0, tag1, index0, index1, word0, word1,
    input next_index0, next_index1, next_word0, next_word1
  );

endinterface

//--- common/itim_ram_if.sv
`timescale 1ns/100ps

interface itim_ram_if #(
  parameter int index_bits = $clog2(itim_cfg_pkg::default_depth),
  parameter int entry_bits = 63 - index_bits - $clog2(itim_cfg_pkg::default_width)
);

  logic wen;
  logic [index_bits-1:0] waddr;
  logic [index_bits-1:0] raddr;
  logic [entry_bits-1:0] wdata;
  // Valid one cycle after raddr is sampled
  logic [entry_bits-1:0] rdata;

  modport ctrl (
    output wen, waddr, raddr, wdata,
    input rdata
  );

  modport bank (
    input wen, waddr, raddr, wdata,
    output rdata
  );

endinterface

//--- common/itim_cfg_pkg.sv
package itim_cfg_pkg;

  // Geometry of the tightly-integrated memory
  localparam int default_depth = 64;
  localparam int default_width = 4;

  // Cacheable window, the top address is exclusive
  localparam logic [31:0] default_base_addr = 32'h0000_0000;
  localparam logic [31:0] default_top_addr = 32'h0001_0000;

  // idle_hit also serves hits without leaving the state
  typedef enum logic [1:0] {
    idle_hit,
    refill,
    bypass,
    fence_clear
  } fetch_state_t;

endpackage

//--- common/mem_bus_pkg.sv
package mem_bus_pkg;

  // Byte address on the fetch port and on the backing bus
  typedef logic [31:0] addr_t;

  // One instruction word
  typedef logic [31:0] word_t;

  // Fetch result, word at addr in the low half and addr+4 in the high half
  typedef logic [63:0] dword_t;

endpackage
